//--- hdl/objdma_consts.svh
//####################################################################
// Sizes and register map of the object DMA block
// The CPU word address is `REG_BIT+1 bits wide, table index below it
//####################################################################
`ifndef OBJDMA_CONSTS_SVH
`define OBJDMA_CONSTS_SVH

// Sprite table geometry
`define OBJ_ENTRIES 32
`define OBJ_WORDS   4
`define TBL_WORDS   (`OBJ_ENTRIES * `OBJ_WORDS)
`define TBL_AW      7
`define DW          16

// CPU address split and entry flags
`define REG_BIT     7
`define EN_BIT      15

// Status register bits
`define STAT_BUSY   0
`define STAT_IRQ    1
`endif

//--- hdl/objdma_pkg.sv
//####################################################################
// Shared types of the object DMA block
// Encodings are fixed, the register select maps to CPU address bits
//####################################################################
`default_nettype none

package objdma_pkg;

    // DMA engine states
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        REQ  = 2'd1,
        COPY = 2'd2,
        DONE = 2'd3
    } dma_state_t;

    // Register select, low CPU address bits in register space
    typedef enum logic [1:0] {
        REG_STATUS  = 2'd0,
        REG_START   = 2'd1,
        REG_IRQ_ACK = 2'd2
    } reg_sel_t;

endpackage

`default_nettype wire

//--- hdl/objdma_wr_if.sv
//####################################################################
// Shadow RAM write port, one word per cycle when we is high
// be is active high, bit 1 is the upper byte
//####################################################################
`default_nettype none
`include "objdma_consts.svh"

interface objdma_wr_if;

    logic              we;
    logic [`TBL_AW-1:0] addr;
    logic [`DW-1:0]    din;
    logic [1:0]        be;

    // Decoder side
    modport src (
        output we,
        output addr,
        output din,
        output be
    );

    // RAM side
    modport dst (
        input  we,
        input  addr,
        input  din,
        input  be
    );

endinterface

`default_nettype wire

//--- hdl/objdma_cpu_dec.sv
//####################################################################
// CPU bus decoder, single cycle strobes and no wait states
// Read data shows up on dout one cycle after the read strobe
//####################################################################
`default_nettype none
`include "objdma_consts.svh"

module objdma_cpu_dec
    import objdma_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    // CPU bus
    input  logic              cs,
    input  logic              cpu_we,
    input  logic [7:0]        addr,
    input  logic [`DW-1:0]    din,
    input  logic [1:0]        dsn,
    output logic [`DW-1:0]    dout,
    // Engine status and control
    input  logic              busy,
    input  logic              irq_pend,
    output logic              start,
    output logic              irq_ack,
    // Shadow RAM
    input  logic [`DW-1:0]    ram_rd_data,
    output logic [`TBL_AW-1:0] ram_rd_addr,
    objdma_wr_if.src          wr
);

    logic              reg_acc;
    reg_sel_t          reg_sel;
    logic [`DW-1:0]    stat_w;
    logic [`DW-1:0]    stat_q;
    logic              rd_ram_q;
    logic              rd_stat_q;

    assign reg_acc = addr[`REG_BIT];
    assign reg_sel = reg_sel_t'(addr[1:0]);

    // RAM writes, dropped when no byte lane is strobed
    assign wr.we   = cs & cpu_we & ~reg_acc & (dsn != 2'b11);
    assign wr.addr = addr[`TBL_AW-1:0];
    assign wr.din  = din;
    assign wr.be   = ~dsn;

    assign ram_rd_addr = addr[`TBL_AW-1:0];

    // Register writes become one cycle strobes
    always_comb begin
        start   = 1'b0;
        irq_ack = 1'b0;
        if (cs && cpu_we && reg_acc) begin
            case (reg_sel)
                REG_START:   start   = 1'b1;
                REG_IRQ_ACK: irq_ack = 1'b1;
                default:     start   = 1'b0;
            endcase
        end
    end

    always_comb begin
        stat_w             = '0;
        stat_w[`STAT_BUSY] = busy;
        stat_w[`STAT_IRQ]  = irq_pend;
    end

    // Remember the read source for the next cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ram_q  <= 1'b0;
            rd_stat_q <= 1'b0;
        end else begin
            rd_ram_q  <= cs & ~cpu_we & ~reg_acc;
            rd_stat_q <= cs & ~cpu_we & reg_acc & (reg_sel == REG_STATUS);
        end
    end

    // Status as it was during the strobe
    always_ff @(posedge clk) begin
        stat_q <= stat_w;
    end

    always_comb begin
        if (rd_ram_q) begin
            dout = ram_rd_data;
        end else if (rd_stat_q) begin
            dout = stat_q;
        end else begin
            dout = '0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/objdma_shadow_ram.sv
//####################################################################
// Shadow sprite RAM, one byte-enable write port and two read ports
// Reads are registered and return old data on a same-cycle write
//####################################################################
`default_nettype none
`include "objdma_consts.svh"

module objdma_shadow_ram (
    input  logic              clk,
    // Write port from the CPU decoder
    objdma_wr_if.dst          wr,
    // CPU read port
    input  logic [`TBL_AW-1:0] a_addr,
    output logic [`DW-1:0]    a_data,
    // DMA read port
    input  logic [`TBL_AW-1:0] b_addr,
    output logic [`DW-1:0]    b_data
);

    logic [`DW-1:0] mem [0:`TBL_WORDS-1];

    // Byte lanes are written separately
    always_ff @(posedge clk) begin
        if (wr.we) begin
            if (wr.be[0]) begin
                mem[wr.addr][7:0] <= wr.din[7:0];
            end
            if (wr.be[1]) begin
                mem[wr.addr][15:8] <= wr.din[15:8];
            end
        end
    end

    // CPU side
    always_ff @(posedge clk) begin
        a_data <= mem[a_addr];
    end

    // DMA side
    always_ff @(posedge clk) begin
        b_data <= mem[b_addr];
    end

endmodule

`default_nettype wire

//--- hdl/objdma_engine.sv
//####################################################################
// Bus master DMA, copies the whole table once the bus is granted
// Disabled entries are sent as zeros, irq_n stays low until acked
//####################################################################
`default_nettype none
`include "objdma_consts.svh"

module objdma_engine
    import objdma_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    // Control from the decoder
    input  logic              start,
    input  logic              irq_ack,
    output logic              busy,
    output logic              irq_n,
    // Shadow RAM read port
    output logic [`TBL_AW-1:0] rd_addr,
    input  logic [`DW-1:0]    rd_data,
    // 68000 style bus arbitration
    input  logic              bg_n,
    output logic              br_n,
    output logic              bgack_n,
    // Object RAM write port
    output logic              oram_we,
    output logic [`TBL_AW-1:0] oram_addr,
    output logic [`DW-1:0]    oram_din
);

    localparam int WORD_W = $clog2(`OBJ_WORDS);

    dma_state_t         state;
    // Extra top bit marks the end of the table
    logic [`TBL_AW:0]   rd_cnt;
    logic               rd_issue;
    logic               wr_vld_q;
    logic [`TBL_AW-1:0] wr_addr_q;
    logic [WORD_W-1:0]  wr_word;
    logic               en_q;
    logic               entry_en;
    logic               last_wr;

    assign rd_addr  = rd_cnt[`TBL_AW-1:0];
    assign rd_issue = (state == COPY) && !rd_cnt[`TBL_AW];
    assign wr_word  = wr_addr_q[WORD_W-1:0];
    assign last_wr  = wr_vld_q && (wr_addr_q == {`TBL_AW{1'b1}});
    assign busy     = (state == REQ) || (state == COPY);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            br_n     <= 1'b1;
            bgack_n  <= 1'b1;
            irq_n    <= 1'b1;
            rd_cnt   <= '0;
            wr_vld_q <= 1'b0;
        end else begin
            wr_vld_q <= rd_issue;
            if (irq_ack) begin
                irq_n <= 1'b1;
            end
            case (state)
                IDLE, DONE: begin
                    if (start) begin
                        br_n   <= 1'b0;
                        rd_cnt <= '0;
                        state  <= REQ;
                    end else begin
                        state  <= IDLE;
                    end
                end
                REQ: begin
                    // Grant seen, take the bus and drop the request
                    if (!bg_n) begin
                        br_n    <= 1'b1;
                        bgack_n <= 1'b0;
                        state   <= COPY;
                    end
                end
                COPY: begin
                    if (rd_issue) begin
                        rd_cnt <= rd_cnt + 1'b1;
                    end
                    if (last_wr) begin
                        bgack_n <= 1'b1;
                        irq_n   <= 1'b0;
                        state   <= DONE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Write stage follows the RAM read latency
    always_ff @(posedge clk) begin
        wr_addr_q <= rd_addr;
        if (wr_vld_q && wr_word == '0) begin
            en_q <= rd_data[`EN_BIT];
        end
    end

    // Word 0 carries its own enable, later words use the latched one
    assign entry_en = (wr_word == '0) ? rd_data[`EN_BIT] : en_q;

    assign oram_we   = wr_vld_q;
    assign oram_addr = wr_addr_q;
    assign oram_din  = entry_en ? rd_data : '0;

endmodule

`default_nettype wire

//--- hdl/objdma_top.sv
//####################################################################
// Object DMA block, CPU bus in and object RAM write port out
// bg_n may answer br_n after any number of cycles
//####################################################################
`default_nettype none
`include "objdma_consts.svh"

module objdma_top (
    input  logic              clk,
    input  logic              rst,
    // CPU bus
    input  logic              cs,
    input  logic              cpu_we,
    input  logic [7:0]        addr,
    input  logic [`DW-1:0]    din,
    input  logic [1:0]        dsn,
    output logic [`DW-1:0]    dout,
    // Bus arbitration
    output logic              br_n,
    input  logic              bg_n,
    output logic              bgack_n,
    // Object RAM
    output logic              oram_we,
    output logic [`TBL_AW-1:0] oram_addr,
    output logic [`DW-1:0]    oram_din,
    output logic              irq_n
);

    logic              start;
    logic              irq_ack;
    logic              busy;
    logic [`TBL_AW-1:0] cpu_rd_addr;
    logic [`DW-1:0]    cpu_rd_data;
    logic [`TBL_AW-1:0] dma_rd_addr;
    logic [`DW-1:0]    dma_rd_data;

    objdma_wr_if wr_bus ();

    objdma_cpu_dec u_dec (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .cs          ( cs          ),
        .cpu_we      ( cpu_we      ),
        .addr        ( addr        ),
        .din         ( din         ),
        .dsn         ( dsn         ),
        .dout        ( dout        ),
        .busy        ( busy        ),
        .irq_pend    ( ~irq_n      ),
        .start       ( start       ),
        .irq_ack     ( irq_ack     ),
        .ram_rd_data ( cpu_rd_data ),
        .ram_rd_addr ( cpu_rd_addr ),
        .wr          ( wr_bus.src  )
    );

    objdma_shadow_ram u_ram (
        .clk         ( clk         ),
        .wr          ( wr_bus.dst  ),
        .a_addr      ( cpu_rd_addr ),
        .a_data      ( cpu_rd_data ),
        .b_addr      ( dma_rd_addr ),
        .b_data      ( dma_rd_data )
    );

    objdma_engine u_engine (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .start       ( start       ),
        .irq_ack     ( irq_ack     ),
        .busy        ( busy        ),
        .irq_n       ( irq_n       ),
        .rd_addr     ( dma_rd_addr ),
        .rd_data     ( dma_rd_data ),
        .bg_n        ( bg_n        ),
        .br_n        ( br_n        ),
        .bgack_n     ( bgack_n     ),
        .oram_we     ( oram_we     ),
        .oram_addr   ( oram_addr   ),
        .oram_din    ( oram_din    )
    );

endmodule

`default_nettype wire

//--- verification/objdma_sva.sv
//####################################################################
// Bus handshake and object RAM strobe rules, bound into the engine
// Sampled on the rising clock edge, idle while rst is high
//####################################################################
`default_nettype none

module objdma_sva (
    input  logic clk,
    input  logic rst,
    input  logic bg_n,
    input  logic br_n,
    input  logic bgack_n,
    input  logic oram_we
);

    // Object RAM is written only while the engine owns the bus
    a_we_owned: assert property (
        @(posedge clk) disable iff (rst)
        oram_we |-> !bgack_n
    ) else $error("oram_we high while bgack_n is high");

    // Bus ownership is taken only after a grant
    a_ack_after_grant: assert property (
        @(posedge clk) disable iff (rst)
        $fell(bgack_n) |-> !$past(bg_n)
    ) else $error("bgack_n fell without a preceding bus grant");

    // Request is dropped once the bus is owned
    a_req_ack_excl: assert property (
        @(posedge clk) disable iff (rst)
        !bgack_n |-> br_n
    ) else $error("br_n and bgack_n low together");

endmodule

bind objdma_engine objdma_sva u_sva (
    .clk     ( clk     ),
    .rst     ( rst     ),
    .bg_n    ( bg_n    ),
    .br_n    ( br_n    ),
    .bgack_n ( bgack_n ),
    .oram_we ( oram_we )
);

`default_nettype wire

//--- verification/objdma_tb.sv
//####################################################################
// Random CPU traffic and a random bus arbiter around objdma_top
// No shadow RAM writes are issued while a copy is running
//####################################################################
`default_nettype none
`include "objdma_consts.svh"

module objdma_tb
    import objdma_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 8000;
    localparam int ROUNDS         = 3;
    localparam int RAND_OPS       = 60;

    logic               clk = 1'b0;
    logic               rst;
    logic               cs;
    logic               cpu_we;
    logic [7:0]         addr;
    logic [`DW-1:0]     din;
    logic [1:0]         dsn;
    logic [`DW-1:0]     dout;
    logic               br_n;
    logic               bg_n = 1'b1;
    logic               bgack_n;
    logic               oram_we;
    logic [`TBL_AW-1:0] oram_addr;
    logic [`DW-1:0]     oram_din;
    logic               irq_n;

    int                 seed;
    int                 err_cnt = 0;
    int                 cyc = 0;
    int                 grant_delay = 0;
    int                 arb_cnt = 0;
    logic               br_s = 1'b1;
    logic               bgack_s = 1'b1;
    logic               gnt_seen = 1'b0;
    int                 gnt_cyc = 0;
    int                 wr_cnt = 0;
    int                 last_wr_cyc = 0;
    // Reference copies of the shadow RAM and the object RAM
    logic [`DW-1:0]     shadow [0:`TBL_WORDS-1];
    logic [`DW-1:0]     oram_model [0:`TBL_WORDS-1];

    objdma_top dut (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .cs        ( cs        ),
        .cpu_we    ( cpu_we    ),
        .addr      ( addr      ),
        .din       ( din       ),
        .dsn       ( dsn       ),
        .dout      ( dout      ),
        .br_n      ( br_n      ),
        .bg_n      ( bg_n      ),
        .bgack_n   ( bgack_n   ),
        .oram_we   ( oram_we   ),
        .oram_addr ( oram_addr ),
        .oram_din  ( oram_din  ),
        .irq_n     ( irq_n     )
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    initial begin
        wait (cyc >= TIMEOUT_CYCLES);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected) begin
            err_cnt = err_cnt + 1;
            $display("error at time %0t: %s, got %0h, expected %0h",
                     $time, msg, actual, expected);
        end
    endtask

    // Zero for every word of an entry whose word 0 has the enable bit clear
    function automatic logic [`DW-1:0] expected_obj_word(input int idx);
        int base;
        base = idx - (idx % `OBJ_WORDS);
        if (shadow[base][`EN_BIT]) begin
            return shadow[idx];
        end
        return '0;
    endfunction

    function automatic logic [7:0] reg_addr(input reg_sel_t sel);
        return 8'(1 << `REG_BIT) | 8'(sel);
    endfunction

    // Arbiter grants grant_delay cycles after the request
    always @(posedge clk) begin
        if (rst) begin
            bg_n    <= 1'b1;
            arb_cnt <= 0;
        end else if (!bgack_s) begin
            bg_n    <= 1'b1;
            arb_cnt <= 0;
        end else if (!br_s && bg_n) begin
            if (arb_cnt >= grant_delay) begin
                bg_n <= 1'b0;
            end else begin
                arb_cnt <= arb_cnt + 1;
            end
        end
    end

    // Object RAM port monitor
    always @(negedge clk) begin
        br_s    = br_n;
        bgack_s = bgack_n;
        if (!rst) begin
            if (!bg_n && !gnt_seen) begin
                gnt_seen = 1'b1;
                gnt_cyc  = cyc;
            end
            if (oram_we) begin
                check(gnt_seen, 1, "object RAM write before the bus grant");
                if (wr_cnt == 0) begin
                    check(cyc, gnt_cyc + 2, "first write not two cycles after the grant");
                end else begin
                    check(cyc, last_wr_cyc + 1, "object RAM writes not back to back");
                end
                check(oram_addr, wr_cnt, "object RAM write address order");
                oram_model[oram_addr] = oram_din;
                wr_cnt      = wr_cnt + 1;
                last_wr_cyc = cyc;
            end
        end
    end

    task automatic cpu_write(input logic [7:0] a, input logic [`DW-1:0] d,
                             input logic [1:0] s);
        @(posedge clk);
        cs     <= 1'b1;
        cpu_we <= 1'b1;
        addr   <= a;
        din    <= d;
        dsn    <= s;
        // Active low strobes select the bytes that change
        if (!a[`REG_BIT]) begin
            if (!s[0]) begin
                shadow[a[`TBL_AW-1:0]][7:0] = d[7:0];
            end
            if (!s[1]) begin
                shadow[a[`TBL_AW-1:0]][15:8] = d[15:8];
            end
        end
        @(posedge clk);
        cs     <= 1'b0;
        cpu_we <= 1'b0;
        dsn    <= 2'b11;
    endtask

    task automatic cpu_read(input logic [7:0] a, output logic [`DW-1:0] d);
        @(posedge clk);
        cs     <= 1'b1;
        cpu_we <= 1'b0;
        addr   <= a;
        dsn    <= 2'b00;
        @(posedge clk);
        cs     <= 1'b0;
        dsn    <= 2'b11;
        @(negedge clk);
        d = dout;
    endtask

    task automatic random_traffic(input int ops);
        int                 n;
        int                 rnd;
        logic [`TBL_AW-1:0] a;
        logic [`DW-1:0]     rdata;
        for (n = 0; n < ops; n++) begin
            rnd = $random(seed);
            a   = rnd[`TBL_AW-1:0];
            if (rnd[12]) begin
                cpu_write({1'b0, a}, rnd[31:16], rnd[9:8]);
            end else begin
                cpu_read({1'b0, a}, rdata);
                check(rdata, shadow[a], "shadow RAM read back");
            end
        end
        // No byte strobe, word must stay as it was
        rnd = $random(seed);
        a   = rnd[`TBL_AW-1:0];
        cpu_write({1'b0, a}, ~shadow[a], 2'b11);
        cpu_read({1'b0, a}, rdata);
        check(rdata, shadow[a], "write without byte strobes changed the RAM");
    endtask

    task automatic run_copy();
        int             i;
        logic [`DW-1:0] rdata;
        grant_delay = $random(seed) & 7;
        gnt_seen    = 1'b0;
        wr_cnt      = 0;
        cpu_write(reg_addr(REG_START), '0, 2'b00);
        do @(negedge clk); while (br_n);
        // Starts while busy must be ignored, while requesting and while copying
        cpu_write(reg_addr(REG_START), '0, 2'b00);
        do @(negedge clk); while (bgack_n);
        cpu_write(reg_addr(REG_START), '0, 2'b00);
        cpu_read(reg_addr(REG_STATUS), rdata);
        check(rdata, 16'h0001, "status during copy");
        do @(negedge clk); while (irq_n);
        check(wr_cnt, `TBL_WORDS, "object RAM writes per copy");
        check(cyc, last_wr_cyc + 1, "irq_n not low the cycle after the last write");
        cpu_read(reg_addr(REG_STATUS), rdata);
        check(rdata, 16'h0002, "status with interrupt pending");
        cpu_write(reg_addr(REG_IRQ_ACK), '0, 2'b00);
        @(negedge clk);
        check(irq_n, 1'b1, "irq_n after acknowledge");
        cpu_read(reg_addr(REG_STATUS), rdata);
        check(rdata, 16'h0000, "status after acknowledge");
        check(wr_cnt, `TBL_WORDS, "extra writes after a start while busy");
        for (i = 0; i < `TBL_WORDS; i++) begin
            check(oram_model[i], expected_obj_word(i), "object RAM word");
        end
    endtask

    initial begin
        int             i;
        int             r;
        logic [`DW-1:0] rdata;
        seed   = 26;
        rst    = 1'b1;
        cs     = 1'b0;
        cpu_we = 1'b0;
        addr   = '0;
        din    = '0;
        dsn    = 2'b11;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check(irq_n, 1'b1, "irq_n after reset");
        check(br_n, 1'b1, "br_n after reset");
        check(bgack_n, 1'b1, "bgack_n after reset");
        check(oram_we, 1'b0, "oram_we after reset");
        check(dout, '0, "dout after reset");
        cpu_read(reg_addr(REG_STATUS), rdata);
        check(rdata, 16'h0000, "status after reset");
        // Whole table gets a known value first
        for (i = 0; i < `TBL_WORDS; i++) begin
            cpu_write(8'(i), 16'($random(seed)), 2'b00);
        end
        for (r = 0; r < ROUNDS; r++) begin
            random_traffic(RAND_OPS);
            run_copy();
        end
        $display("checks done with %0d errors", err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+hdl
hdl/objdma_pkg.sv
hdl/objdma_wr_if.sv
hdl/objdma_cpu_dec.sv
hdl/objdma_shadow_ram.sv
hdl/objdma_engine.sv
hdl/objdma_top.sv
verification/objdma_sva.sv
verification/objdma_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the object DMA testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module objdma_tb -o objdma_sim

status=0
./obj_dir/objdma_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation failed" sim.log || [ "$status" -ne 0 ]; then
    echo "run failed, see sim.log"
    exit 1
fi
